// ==== hdl/soc_bus_pkg.sv ====
// fabric bus package with data and address widths, address map and main memory size

package soc_bus_pkg;

    ////////////////////////////////////////
    // bus word types
    ////////////////////////////////////////

    typedef logic [31:0] bus_addr_t;                      // byte address
    typedef logic [31:0] bus_data_t;                      // data word

    ////////////////////////////////////////
    // main memory
    ////////////////////////////////////////

    localparam bus_addr_t MEM_BASE  = 32'h0000_0000;      // bottom of the map
    localparam int        MEM_WORDS = 256;                // 1 KiB of words

    // byte size of the memory window, power of two
    localparam bus_addr_t MEM_BYTES = bus_addr_t'(MEM_WORDS * 4);

    typedef logic [7:0] mem_idx_t;                        // word index, addr[9:2]

    ////////////////////////////////////////
    // interrupt controller window
    ////////////////////////////////////////

    localparam bus_addr_t PLIC_BASE = 32'h0C00_0000;      // same base as the full soc
    localparam bus_addr_t PLIC_SPAN = 32'h0000_1000;      // 4 KiB, aligned

    // everything else in the map is a hole

endpackage : soc_bus_pkg

// ==== hdl/soc_irq_pkg.sv ====
// interrupt controller package with source count, id and priority types, offsets and gateway states

package soc_irq_pkg;

    ////////////////////////////////////////
    // sources and ids
    ////////////////////////////////////////

    localparam int NUM_SRC = 4;                           // ids 1..4, id 0 reserved

    typedef logic [2:0]         irq_id_t;                 // 0 means no source
    typedef logic [2:0]         irq_prio_t;               // 0 never beats threshold
    typedef logic [NUM_SRC-1:0] irq_src_vec_t;            // bit k is id k+1

    typedef irq_prio_t [NUM_SRC-1:0] irq_prio_arr_t;      // entry k is id k+1

    ////////////////////////////////////////
    // register offsets in the window
    ////////////////////////////////////////

    typedef logic [11:0] plic_ofs_t;                      // offset inside 4 KiB

    localparam plic_ofs_t PRIO_OFS   = 12'h000;           // id k at PRIO_OFS + 4*k
    localparam plic_ofs_t PEND_OFS   = 12'h080;           // read only
    localparam plic_ofs_t ENABLE_OFS = 12'h100;           // bits 4:1
    localparam plic_ofs_t THRESH_OFS = 12'h180;
    localparam plic_ofs_t CLAIM_OFS  = 12'h184;           // read claims, write completes

    ////////////////////////////////////////
    // gateway fsm
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE    = 2'd0,                                   // waiting for the line
        PENDING = 2'd1,                                   // visible to the target
        CLAIMED = 2'd2                                    // in service, line masked
    } gw_state_e;

endpackage : soc_irq_pkg

// ==== hdl/soc_bus_if.sv ====
// strobe request and read response bundle between the address decoder and one slave

interface soc_bus_if
    import soc_bus_pkg::*;
();

    logic      valid;                                     // one-cycle request strobe
    logic      we;                                        // 1 write, 0 read
    bus_addr_t addr;                                      // full byte address
    bus_data_t wdata;                                     // write payload
    logic      rvalid;                                    // read answer, one cycle later
    bus_data_t rdata;                                     // read payload

    // decoder side
    modport master (
        output valid,
        output we,
        output addr,
        output wdata,
        input  rvalid,
        input  rdata
    );

    // memory or plic side, always ready
    modport slave (
        input  valid,
        input  we,
        input  addr,
        input  wdata,
        output rvalid,
        output rdata
    );

endinterface : soc_bus_if

// ==== hdl/bus_decoder.sv ====
// address decoder steering the single master request to memory or plic, with response mux

module bus_decoder
    import soc_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  logic      req_we_i,
    input  bus_addr_t req_addr_i,
    input  bus_data_t req_wdata_i,
    soc_bus_if.master mem_bus,
    soc_bus_if.master plic_bus,
    output logic      rsp_valid_o,
    output bus_data_t rsp_rdata_o,
    output logic      rsp_err_o
);

    logic hit_mem;                                        // inside memory window
    logic hit_plic;                                       // inside plic window
    logic miss_rd;                                        // read into a hole
    logic err_q;                                          // pending error answer

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    // both windows are power-of-two sized and aligned
    assign hit_mem  = (req_addr_i & ~(MEM_BYTES - 1)) == MEM_BASE;
    assign hit_plic = (req_addr_i & ~(PLIC_SPAN - 1)) == PLIC_BASE;
    assign miss_rd  = req_valid_i & ~req_we_i & ~hit_mem & ~hit_plic;

    ////////////////////////////////////////
    // request steering
    ////////////////////////////////////////

    assign mem_bus.valid  = req_valid_i & hit_mem;        // at most one strobe fires
    assign mem_bus.we     = req_we_i;
    assign mem_bus.addr   = req_addr_i;
    assign mem_bus.wdata  = req_wdata_i;

    assign plic_bus.valid = req_valid_i & hit_plic;
    assign plic_bus.we    = req_we_i;
    assign plic_bus.addr  = req_addr_i;
    assign plic_bus.wdata = req_wdata_i;

    // unmapped writes just vanish, unmapped reads answer next cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= miss_rd;                             // aligns with slave rvalid
        end
    end

    ////////////////////////////////////////
    // response mux
    ////////////////////////////////////////

    assign rsp_valid_o = mem_bus.rvalid | plic_bus.rvalid | err_q;
    assign rsp_err_o   = err_q;

    always_comb begin
        if (mem_bus.rvalid) begin
            rsp_rdata_o = mem_bus.rdata;
        end else if (plic_bus.rvalid) begin
            rsp_rdata_o = plic_bus.rdata;
        end else begin
            rsp_rdata_o = '0;                             // error and idle read zero
        end
    end

endmodule : bus_decoder

// ==== hdl/main_memory.sv ====
// word-addressed synchronous ram slave answering reads one cycle after the strobe

module main_memory
    import soc_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    soc_bus_if.slave bus
);

    bus_data_t mem_q [MEM_WORDS];                         // storage array
    mem_idx_t  idx;                                       // word select
    bus_data_t rdata_q;                                   // read data register
    logic      rvalid_q;                                  // read answer strobe

    assign idx = bus.addr[9:2];                           // drop byte offset

    // array and read port, contents undefined until written
    always_ff @(posedge clk_i) begin
        if (bus.valid & bus.we) begin
            mem_q[idx] <= bus.wdata;
        end
        if (bus.valid & ~bus.we) begin
            rdata_q <= mem_q[idx];                        // old data on same word
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.valid & ~bus.we;              // every read answers
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule : main_memory

// ==== hdl/plic_regs.sv ====
// plic register file with priority, enable, threshold, pending view and claim/complete pulses

module plic_regs
    import soc_bus_pkg::*;
    import soc_irq_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    soc_bus_if.slave      bus,
    input  irq_src_vec_t  pending_i,
    input  irq_id_t       best_id_i,
    output irq_prio_arr_t prio_o,
    output irq_src_vec_t  enable_o,
    output irq_prio_t     threshold_o,
    output irq_src_vec_t  claim_o,
    output irq_src_vec_t  complete_o
);

    plic_ofs_t     ofs;                                   // offset in window
    logic          rd_req;                                // read strobe
    logic          wr_req;                                // write strobe
    irq_src_vec_t  prio_sel;                              // one-hot priority hit
    logic          en_sel;
    logic          thr_sel;
    logic          pend_sel;
    logic          claim_sel;

    irq_prio_arr_t prio_q;
    irq_src_vec_t  enable_q;
    irq_prio_t     thresh_q;
    bus_data_t     rdata_d;
    bus_data_t     rdata_q;
    logic          rvalid_q;

    ////////////////////////////////////////
    // offset decode
    ////////////////////////////////////////

    assign ofs       = plic_ofs_t'(bus.addr);             // decoder checked the base
    assign rd_req    = bus.valid & ~bus.we;
    assign wr_req    = bus.valid & bus.we;
    assign en_sel    = ofs == ENABLE_OFS;
    assign thr_sel   = ofs == THRESH_OFS;
    assign pend_sel  = ofs == PEND_OFS;
    assign claim_sel = ofs == CLAIM_OFS;

    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            prio_sel[k] = ofs == PRIO_OFS + plic_ofs_t'(4 * (k + 1));  // id 0 slot unused
        end
    end

    ////////////////////////////////////////
    // read mux, claim and complete
    ////////////////////////////////////////

    always_comb begin
        rdata_d = '0;                                     // holes read zero
        for (int k = 0; k < NUM_SRC; k++) begin
            if (prio_sel[k]) begin
                rdata_d = bus_data_t'(prio_q[k]);
            end
        end
        if (pend_sel)  rdata_d = bus_data_t'({pending_i, 1'b0});  // bit 0 is id 0
        if (en_sel)    rdata_d = bus_data_t'({enable_q, 1'b0});
        if (thr_sel)   rdata_d = bus_data_t'(thresh_q);
        if (claim_sel) rdata_d = bus_data_t'(best_id_i);
    end

    // same-cycle pulses, the gateway moves on the closing edge
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            claim_o[k]    = rd_req & claim_sel & (best_id_i == irq_id_t'(k + 1));
            complete_o[k] = wr_req & claim_sel & (bus.wdata == bus_data_t'(k + 1));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q   <= '0;
            enable_q <= '0;
            thresh_q <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_req;
            if (wr_req) begin
                for (int k = 0; k < NUM_SRC; k++) begin
                    if (prio_sel[k]) prio_q[k] <= irq_prio_t'(bus.wdata);
                end
                if (en_sel)  enable_q <= bus.wdata[NUM_SRC:1];     // bit 0 ignored
                if (thr_sel) thresh_q <= irq_prio_t'(bus.wdata);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_req) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = thresh_q;

endmodule : plic_regs

// ==== hdl/irq_gateway.sv ====
// per-source interrupt gateway holding one level request until it is claimed and completed

module irq_gateway
    import soc_irq_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic src_i,                                   // level line from peripheral
    input  logic claim_i,                                 // pulse from claim read
    input  logic complete_i,                              // pulse from claim write
    output logic pending_o
);

    gw_state_e state_q;
    gw_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (src_i) state_d = PENDING;             // sampled every edge
            end
            PENDING: begin
                if (claim_i) state_d = CLAIMED;
            end
            CLAIMED: begin
                if (complete_i) state_d = IDLE;           // line may re-arm next edge
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // claimed sources stay hidden while their line is high
    assign pending_o = state_q == PENDING;

endmodule : irq_gateway

// ==== hdl/plic_target.sv ====
// plic target picking the highest-priority enabled pending source and driving the external irq

module plic_target
    import soc_irq_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  irq_src_vec_t  pending_i,
    input  irq_prio_arr_t prio_i,
    input  irq_src_vec_t  enable_i,
    input  irq_prio_t     threshold_i,
    output irq_id_t       best_id_o,
    output logic          irq_o
);

    irq_id_t   best_id_d;                                 // winner this cycle
    irq_prio_t best_prio;                                 // bar to beat

    ////////////////////////////////////////
    // selection
    ////////////////////////////////////////

    // scan from id 1 upward, strict compare keeps the lowest id on ties
    always_comb begin
        best_id_d = '0;
        best_prio = threshold_i;                          // must exceed threshold
        for (int k = 0; k < NUM_SRC; k++) begin
            if (pending_i[k] && enable_i[k] && (prio_i[k] > best_prio)) begin
                best_id_d = irq_id_t'(k + 1);
                best_prio = prio_i[k];
            end
        end
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            best_id_o <= '0;
            irq_o     <= 1'b0;
        end else begin
            best_id_o <= best_id_d;                       // claim value
            irq_o     <= best_id_d != '0;                 // ext irq, level
        end
    end

endmodule : plic_target

// ==== hdl/mini_soc.sv ====
// mini soc top with decoder, main memory, plic registers, gateways and interrupt target

module mini_soc
    import soc_bus_pkg::*;
    import soc_irq_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         req_valid_i,
    input  logic         req_we_i,
    input  bus_addr_t    req_addr_i,
    input  bus_data_t    req_wdata_i,
    input  irq_src_vec_t irq_src_i,                       // bit k is id k+1
    output logic         rsp_valid_o,
    output bus_data_t    rsp_rdata_o,
    output logic         rsp_err_o,
    output logic         irq_o
);

    soc_bus_if mem_bus  ();                               // decoder -> memory
    soc_bus_if plic_bus ();                               // decoder -> plic

    irq_src_vec_t  gw_pending;                            // gateways -> target, regs
    irq_src_vec_t  gw_claim;                              // regs -> gateways
    irq_src_vec_t  gw_complete;
    irq_src_vec_t  plic_enable;
    irq_prio_arr_t plic_prio;
    irq_prio_t     plic_threshold;
    irq_id_t       best_id;                               // target -> regs

    ////////////////////////////////////////
    // bus fabric
    ////////////////////////////////////////

    bus_decoder decoder_u (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_valid_i ( req_valid_i ),
        .req_we_i    ( req_we_i    ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .mem_bus     ( mem_bus     ),
        .plic_bus    ( plic_bus    ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_err_o   ( rsp_err_o   )
    );

    main_memory main_memory_u (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .bus     ( mem_bus )
    );

    ////////////////////////////////////////
    // interrupt controller
    ////////////////////////////////////////

    plic_regs plic_regs_u (
        .clk_i       ( clk_i          ),
        .rst_n_i     ( rst_n_i        ),
        .bus         ( plic_bus       ),
        .pending_i   ( gw_pending     ),
        .best_id_i   ( best_id        ),
        .prio_o      ( plic_prio      ),
        .enable_o    ( plic_enable    ),
        .threshold_o ( plic_threshold ),
        .claim_o     ( gw_claim       ),
        .complete_o  ( gw_complete    )
    );

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_gw
        irq_gateway gateway_u (
            .clk_i      ( clk_i          ),
            .rst_n_i    ( rst_n_i        ),
            .src_i      ( irq_src_i[i]   ),
            .claim_i    ( gw_claim[i]    ),
            .complete_i ( gw_complete[i] ),
            .pending_o  ( gw_pending[i]  )
        );
    end

    plic_target plic_target_u (
        .clk_i       ( clk_i          ),
        .rst_n_i     ( rst_n_i        ),
        .pending_i   ( gw_pending     ),
        .prio_i      ( plic_prio      ),
        .enable_i    ( plic_enable    ),
        .threshold_i ( plic_threshold ),
        .best_id_o   ( best_id        ),
        .irq_o       ( irq_o          )               // external interrupt line
    );

endmodule : mini_soc

// ==== verif/mini_soc_assert.sv ====
// protocol checker bound to the mini soc top for response strobes and the interrupt line

module mini_soc_assert
    import soc_bus_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      req_valid_i,
    input logic      req_we_i,
    input logic      rsp_valid_i,
    input bus_data_t rsp_rdata_i,
    input logic      rsp_err_i,
    input logic      irq_i
);

    ////////////////////////////////////////
    // response timing
    ////////////////////////////////////////

    rsp_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_valid_i && !req_we_i) |=> rsp_valid_i)
        else $error("read got no response one cycle later");

    rsp_only_for_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(req_valid_i && !req_we_i))
        else $error("response without a read one cycle before");

    // hole reads answer with the strobe and all-zero data
    err_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_err_i |-> (rsp_valid_i && rsp_rdata_i == '0))
        else $error("error flag without response strobe or with nonzero data");

    // external line never floats once out of reset
    irq_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(irq_i))
        else $error("irq line unknown");

endmodule : mini_soc_assert

bind mini_soc mini_soc_assert assert_u (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_we_i    ( req_we_i    ),
    .rsp_valid_i ( rsp_valid_o ),
    .rsp_rdata_i ( rsp_rdata_o ),
    .rsp_err_i   ( rsp_err_o   ),
    .irq_i       ( irq_o       )
);

// ==== verif/tb_mini_soc.sv ====
// testbench for the mini soc driving lfsr stimulus and checking against a cycle model

module tb_mini_soc
    import soc_bus_pkg::*;
    import soc_irq_pkg::*;
();

    localparam logic [31:0] SEED    = 32'h448f_e97e;
    localparam int          TIMEOUT = 8;                  // cycles per wait

    logic          clk;
    logic          rst_n;
    logic          req_valid;
    logic          req_we;
    bus_addr_t     req_addr;
    bus_data_t     req_wdata;
    irq_src_vec_t  irq_src;
    logic          rsp_valid;
    bus_data_t     rsp_rdata;
    logic          rsp_err;
    logic          irq;

    logic [31:0]   lfsr;                                  // stimulus state
    bus_data_t     mem_m [MEM_WORDS];                     // memory model
    irq_prio_arr_t prio_m;
    irq_src_vec_t  en_m;
    irq_prio_t     thr_m;
    gw_state_e     gw_m [NUM_SRC];                        // gateway model
    irq_id_t       best_m;                                // registered claim value
    mem_idx_t      written [$];                           // words with known contents
    bus_data_t     d;
    irq_id_t       id;

    mini_soc DUT (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_we_i    ( req_we    ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .irq_src_i   ( irq_src   ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_err_o   ( rsp_err   ),
        .irq_o       ( irq       )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                            // period 4
    end

    ////////////////////////////////////////
    // stimulus and error helpers
    ////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_now();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_err(input string name, input logic [31:0] want, input logic [31:0] got);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, want, got);
        fail_now();
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic in_mem(input bus_addr_t a);
        return (a - MEM_BASE) < bus_addr_t'(MEM_WORDS * 4);   // wraps below base
    endfunction

    function automatic logic in_plic(input bus_addr_t a);
        return (a - PLIC_BASE) < PLIC_SPAN;
    endfunction

    function automatic bus_addr_t plic_addr(input plic_ofs_t o);
        return PLIC_BASE + bus_addr_t'(o);
    endfunction

    function automatic bus_addr_t prio_addr(input int k);
        return plic_addr(PRIO_OFS + plic_ofs_t'(4 * k));      // id k
    endfunction

    // 0-based source slot of a priority offset, -1 otherwise
    function automatic int prio_slot(input plic_ofs_t o);
        plic_ofs_t r;
        r = o - PRIO_OFS;
        if (r[1:0] == 2'b00 && r >= 12'h004 && r <= 12'h010) return int'(r[4:2]) - 1;
        return -1;
    endfunction

    function automatic irq_src_vec_t pend_m();
        irq_src_vec_t p;
        for (int k = 0; k < NUM_SRC; k++) begin
            p[k] = gw_m[k] == PENDING;
        end
        return p;
    endfunction

    // downward scan, ties go to the lower id
    function automatic irq_id_t model_best();
        irq_id_t   w;
        irq_prio_t wp;
        w  = '0;
        wp = '0;
        for (int k = NUM_SRC - 1; k >= 0; k--) begin
            if (gw_m[k] == PENDING && en_m[k] && prio_m[k] > thr_m && prio_m[k] >= wp) begin
                w  = irq_id_t'(k + 1);
                wp = prio_m[k];
            end
        end
        return w;
    endfunction

    function automatic bus_data_t model_read(input bus_addr_t a);
        plic_ofs_t o;
        int        s;
        o = plic_ofs_t'(a - PLIC_BASE);
        s = prio_slot(o);
        if (in_mem(a)) return mem_m[a[9:2]];
        if (!in_plic(a)) return '0;                       // hole, error with zero data
        if (s >= 0) return bus_data_t'(prio_m[s]);
        case (o)
            PEND_OFS:   return bus_data_t'({pend_m(), 1'b0});
            ENABLE_OFS: return bus_data_t'({en_m, 1'b0});
            THRESH_OFS: return bus_data_t'(thr_m);
            CLAIM_OFS:  return bus_data_t'(best_m);
            default:    return '0;
        endcase
    endfunction

    function automatic void model_write(input bus_addr_t a, input bus_data_t wd);
        plic_ofs_t o;
        int        s;
        o = plic_ofs_t'(a - PLIC_BASE);
        s = prio_slot(o);
        if (in_mem(a)) begin
            mem_m[a[9:2]] = wd;
        end else if (in_plic(a)) begin
            if (s >= 0) prio_m[s] = wd[2:0];
            if (o == ENABLE_OFS) en_m = wd[NUM_SRC:1];
            if (o == THRESH_OFS) thr_m = wd[2:0];
        end
    endfunction

    ////////////////////////////////////////
    // one clock with model update and checks
    ////////////////////////////////////////

    task automatic step();
        logic      rd;
        logic      hit_claim;
        logic      exp_e;
        bus_data_t exp_d;
        irq_id_t   nb;
        rd        = req_valid && !req_we;
        hit_claim = req_valid && in_plic(req_addr)
                    && plic_ofs_t'(req_addr - PLIC_BASE) == CLAIM_OFS;
        exp_d     = model_read(req_addr);                 // pre-edge state
        exp_e     = rd && !in_mem(req_addr) && !in_plic(req_addr);
        nb        = model_best();
        if (req_valid && req_we) model_write(req_addr, req_wdata);
        for (int k = 0; k < NUM_SRC; k++) begin
            case (gw_m[k])
                IDLE:    if (irq_src[k]) gw_m[k] = PENDING;
                PENDING: if (hit_claim && rd && best_m == irq_id_t'(k + 1)) gw_m[k] = CLAIMED;
                default: if (hit_claim && req_we && req_wdata == bus_data_t'(k + 1)) gw_m[k] = IDLE;
            endcase
        end
        best_m = nb;
        @(posedge clk);
        #1;                                               // outputs settled
        assert (rsp_valid === rd) else value_err("rsp_valid_o", 32'(rd), 32'(rsp_valid));
        assert (rsp_err === exp_e) else value_err("rsp_err_o", 32'(exp_e), 32'(rsp_err));
        if (rd) assert (rsp_rdata === exp_d) else value_err("rsp_rdata_o", exp_d, rsp_rdata);
        assert (irq === (best_m != '0)) else value_err("irq_o", 32'(best_m != '0), 32'(irq));
        req_valid = 1'b0;
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t wd);
        req_valid = 1'b1;
        req_we    = 1'b1;
        req_addr  = a;
        req_wdata = wd;
        step();
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_data_t rd_data);
        req_valid = 1'b1;
        req_we    = 1'b0;
        req_addr  = a;
        step();
        rd_data = rsp_rdata;                              // answer of this read
    endtask

    task automatic wait_irq(input logic lvl);
        int n;
        n = 0;
        while (irq !== lvl) begin
            if (n == TIMEOUT) begin
                $display("timeout while waiting for irq_o to reach %b", lvl);
                fail_now();
            end
            step();
            n++;
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        lfsr      = SEED;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        irq_src   = '0;
        prio_m    = '0;
        en_m      = '0;
        thr_m     = '0;
        best_m    = '0;
        for (int k = 0; k < NUM_SRC; k++) gw_m[k] = IDLE;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (rsp_valid === 1'b0 && rsp_err === 1'b0 && irq === 1'b0)
            else value_err("rsp_valid_o rsp_err_o irq_o", '0, 32'({rsp_valid, rsp_err, irq}));

        // memory writes, then reads back to back
        for (int i = 0; i < 16; i++) begin
            written.push_back(mem_idx_t'(rand_bits(8)));
            bus_write(MEM_BASE + bus_addr_t'({written[i], 2'b00}), rand_bits(32));
        end
        foreach (written[i]) bus_read(MEM_BASE + bus_addr_t'({written[i], 2'b00}), d);

        // holes above both windows
        for (int i = 0; i < 8; i++) bus_read(rand_bits(32) | 32'h8000_0000, d);
        for (int i = 0; i < 8; i++) bus_write(rand_bits(32) | 32'h8000_0000, rand_bits(32));
        foreach (written[i]) bus_read(MEM_BASE + bus_addr_t'({written[i], 2'b00}), d);

        // register write and masked readback
        for (int i = 0; i < 8; i++) begin
            for (int k = 1; k <= NUM_SRC; k++) bus_write(prio_addr(k), rand_bits(32));
            bus_write(plic_addr(ENABLE_OFS), rand_bits(32));
            bus_write(plic_addr(THRESH_OFS), rand_bits(32));
            for (int k = 1; k <= NUM_SRC; k++) bus_read(prio_addr(k), d);
            bus_read(plic_addr(ENABLE_OFS), d);
            bus_read(plic_addr(THRESH_OFS), d);
        end

        // interrupt rounds, claim then complete
        for (int r = 0; r < 12; r++) begin
            for (int k = 1; k <= NUM_SRC; k++) bus_write(prio_addr(k), rand_bits(3));
            bus_write(plic_addr(ENABLE_OFS), rand_bits(NUM_SRC) << 1);
            bus_write(plic_addr(THRESH_OFS), rand_bits(2));
            irq_src = irq_src_vec_t'(rand_bits(NUM_SRC));
            step();
            step();
            wait_irq(model_best() != '0);
            bus_read(plic_addr(CLAIM_OFS), d);
            id = irq_id_t'(d);
            if (id != '0) begin
                irq_src = irq_src | (irq_src_vec_t'(1) << (id - irq_id_t'(1)));  // hold line
                bus_read(plic_addr(PEND_OFS), d);
                assert ((d & (32'h1 << id)) == '0)
                    else value_err("claimed pending bit", '0, d & (32'h1 << id));
                bus_write(plic_addr(CLAIM_OFS), bus_data_t'(id));
                step();
                bus_read(plic_addr(PEND_OFS), d);
                assert ((d & (32'h1 << id)) != '0)
                    else value_err("re-armed pending bit", 32'h1 << id, d & (32'h1 << id));
            end
        end

        // threshold 7 leaves nothing qualifying
        bus_write(plic_addr(THRESH_OFS), 32'h7);
        step();
        step();
        wait_irq(1'b0);
        bus_read(plic_addr(CLAIM_OFS), d);
        assert (d === '0) else value_err("rsp_rdata_o", '0, d);

        $display("Test passed");
        $finish;
    end

endmodule : tb_mini_soc

// ==== flist.f ====
hdl/soc_bus_pkg.sv
hdl/soc_irq_pkg.sv
hdl/soc_bus_if.sv
hdl/bus_decoder.sv
hdl/main_memory.sv
hdl/plic_regs.sv
hdl/irq_gateway.sv
hdl/plic_target.sv
hdl/mini_soc.sv
verif/mini_soc_assert.sv
verif/tb_mini_soc.sv

// ==== Makefile ====
# Verilator flow for the mini soc testbench

VERILATOR  ?= verilator
TOP        := tb_mini_soc
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
SOURCES    := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
